// ==== design/rv_isa_pkg.sv ====
package rv_isa_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] xlen_t;      // machine word
  typedef logic [31:0]     inst_t;      // raw instruction word
  typedef logic [4:0]      reg_addr_t;  // x0..x31
  typedef logic [4:0]      shamt_t;     // shift amount, low bits of operand b
  typedef logic [2:0]      funct3_t;
  typedef logic [6:0]      funct7_t;

  // major opcodes kept by this core
  typedef enum logic [6:0] {
    OP     = 7'b011_0011,
    OP_IMM = 7'b001_0011,
    LUI    = 7'b011_0111,
    AUIPC  = 7'b001_0111,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    BRANCH = 7'b110_0011,
    SYSTEM = 7'b111_0011
  } opcode_e;

  // funct3 of OP / OP_IMM
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // funct3 of BRANCH
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  localparam funct7_t FUNCT7_ALT = 7'b010_0000;  // sub, sra, srai

  // the whole word is fixed for ebreak
  localparam inst_t INST_EBREAK = 32'h0010_0073;

endpackage

// ==== design/core_pkg.sv ====
package core_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // source of the register write-back value
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LINK,    // pc + 4 for jal / jalr
    WB_IMM,     // lui
    WB_PC_IMM   // auipc
  } wb_sel_e;

  // one decoded instruction, held between decode and execute
  typedef struct packed {
    rv_isa_pkg::xlen_t     pc;
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::reg_addr_t rs1;
    rv_isa_pkg::reg_addr_t rs2;
    rv_isa_pkg::xlen_t     imm;
    alu_op_e               alu_op;
    logic                  use_imm;   // operand b from imm, not rs2
    wb_sel_e               wb_sel;
    logic                  reg_we;
    logic                  is_branch;
    rv_isa_pkg::funct3_t   funct3;    // branch condition
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_halt;
  } decoded_t;

  // what the core reports each time an instruction completes
  typedef struct packed {
    logic                  valid;
    rv_isa_pkg::xlen_t     pc;
    rv_isa_pkg::reg_addr_t rd;
    logic                  we;
    rv_isa_pkg::xlen_t     wdata;
    rv_isa_pkg::xlen_t     next_pc;
  } retire_t;

endpackage

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit #(
  parameter rv_isa_pkg::xlen_t reset_pc = 32'h8000_0000
) (
  input  logic              clk,
  input  logic              arst_n,
  output logic              psel,
  output logic              penable,
  output rv_isa_pkg::xlen_t paddr,
  input  rv_isa_pkg::inst_t prdata,
  input  logic              pready,
  input  logic              redirect_valid,
  input  rv_isa_pkg::xlen_t redirect_pc,
  input  logic              halt,
  output logic              fetch_valid,
  output rv_isa_pkg::inst_t fetch_inst,
  output rv_isa_pkg::xlen_t fetch_pc,
  output logic              halted
);
  import rv_isa_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    SETUP,
    ACCESS,
    WAIT_EXEC,
    HALTED
  } fetch_state_e;

  fetch_state_e state;
  fetch_state_e state_nxt;
  xlen_t        pc;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:      state_nxt = SETUP;
      SETUP:     state_nxt = ACCESS;
      ACCESS:    if (pready) state_nxt = WAIT_EXEC;  // wait states just stretch this
      WAIT_EXEC: begin
        if (redirect_valid) begin
          state_nxt = halt ? HALTED : SETUP;
        end
      end
      HALTED:    state_nxt = HALTED;  // only reset leaves
      default:   state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= IDLE;
      pc    <= reset_pc;
    end else begin
      state <= state_nxt;
      // next fetch address comes from execute
      if (state == WAIT_EXEC && redirect_valid && !halt) begin
        pc <= redirect_pc;
      end
    end
  end

  // apb requester, read only
  assign psel    = (state == SETUP) || (state == ACCESS);
  assign penable = (state == ACCESS);
  assign paddr   = pc;  // held for the whole transfer

  assign fetch_valid = (state == ACCESS) && pready;
  assign fetch_inst  = prdata;
  assign fetch_pc    = pc;
  assign halted      = (state == HALTED);

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 fetch_valid,
  input  rv_isa_pkg::inst_t    fetch_inst,
  input  rv_isa_pkg::xlen_t    fetch_pc,
  output logic                 dec_valid,
  output core_pkg::decoded_t   dec
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  opcode_e  opcode;
  funct3_t  funct3;
  funct7_t  funct7;
  xlen_t    imm_i;
  xlen_t    imm_u;
  xlen_t    imm_j;
  xlen_t    imm_b;
  alu_op_e  alu_op_f3;  // op picked by funct3, shared by OP and OP_IMM
  decoded_t dec_d;

  assign opcode = opcode_e'(fetch_inst[6:0]);
  assign funct3 = fetch_inst[14:12];
  assign funct7 = fetch_inst[31:25];

  // sign extended immediates
  assign imm_i = {{20{fetch_inst[31]}}, fetch_inst[31:20]};
  assign imm_u = {fetch_inst[31:12], 12'h000};
  assign imm_j = {{12{fetch_inst[31]}}, fetch_inst[19:12], fetch_inst[20],
                  fetch_inst[30:21], 1'b0};
  assign imm_b = {{20{fetch_inst[31]}}, fetch_inst[7], fetch_inst[30:25],
                  fetch_inst[11:8], 1'b0};

  always_comb begin
    case (funct3)
      F3_SLL:     alu_op_f3 = ALU_SLL;
      F3_SLT:     alu_op_f3 = ALU_SLT;
      F3_SLTU:    alu_op_f3 = ALU_SLTU;
      F3_XOR:     alu_op_f3 = ALU_XOR;
      F3_SRL_SRA: alu_op_f3 = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;  // srai too
      F3_OR:      alu_op_f3 = ALU_OR;
      F3_AND:     alu_op_f3 = ALU_AND;
      default:    alu_op_f3 = ALU_ADD;
    endcase
  end

  always_comb begin
    // unknown opcode leaves a plain fall-through with no write
    dec_d           = '0;
    dec_d.pc        = fetch_pc;
    dec_d.rd        = fetch_inst[11:7];
    dec_d.rs1       = fetch_inst[19:15];
    dec_d.rs2       = fetch_inst[24:20];
    dec_d.funct3    = funct3;
    dec_d.alu_op    = ALU_ADD;
    dec_d.wb_sel    = WB_ALU;
    case (opcode)
      OP: begin
        dec_d.reg_we = 1'b1;
        dec_d.alu_op = (funct3 == F3_ADD_SUB && funct7 == FUNCT7_ALT) ? ALU_SUB : alu_op_f3;
      end
      OP_IMM: begin
        dec_d.reg_we  = 1'b1;
        dec_d.use_imm = 1'b1;
        dec_d.imm     = imm_i;
        dec_d.alu_op  = alu_op_f3;  // no subi
      end
      LUI: begin
        dec_d.reg_we = 1'b1;
        dec_d.imm    = imm_u;
        dec_d.wb_sel = WB_IMM;
      end
      AUIPC: begin
        dec_d.reg_we = 1'b1;
        dec_d.imm    = imm_u;
        dec_d.wb_sel = WB_PC_IMM;
      end
      JAL: begin
        dec_d.reg_we = 1'b1;
        dec_d.imm    = imm_j;
        dec_d.wb_sel = WB_LINK;
        dec_d.is_jal = 1'b1;
      end
      JALR: begin
        dec_d.reg_we  = 1'b1;
        dec_d.imm     = imm_i;
        dec_d.wb_sel  = WB_LINK;
        dec_d.is_jalr = 1'b1;
      end
      BRANCH: begin
        dec_d.imm       = imm_b;
        dec_d.is_branch = 1'b1;
      end
      SYSTEM:  dec_d.is_halt = (fetch_inst == INST_EBREAK);  // other system ops do nothing
      default: dec_d.reg_we  = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= fetch_valid;  // one cycle pulse per fetched word
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid) begin
      dec <= dec_d;
    end
  end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic                  clk,
  input  logic                  arst_n,
  input  rv_isa_pkg::reg_addr_t rs1_addr,
  input  rv_isa_pkg::reg_addr_t rs2_addr,
  output rv_isa_pkg::xlen_t     rs1_data,
  output rv_isa_pkg::xlen_t     rs2_data,
  input  logic                  we,
  input  rv_isa_pkg::reg_addr_t waddr,
  input  rv_isa_pkg::xlen_t     wdata
);
  import rv_isa_pkg::*;

  xlen_t regs [NUM_REGS];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin  // x0 never written
      regs[waddr] <= wdata;
    end
  end

  // read ports are combinational
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== design/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit (
  input  logic                  dec_valid,
  input  core_pkg::decoded_t    dec,
  output rv_isa_pkg::reg_addr_t rs1_addr,
  output rv_isa_pkg::reg_addr_t rs2_addr,
  input  rv_isa_pkg::xlen_t     rs1_data,
  input  rv_isa_pkg::xlen_t     rs2_data,
  output logic                  rf_we,
  output rv_isa_pkg::reg_addr_t rf_waddr,
  output rv_isa_pkg::xlen_t     rf_wdata,
  output logic                  redirect_valid,
  output rv_isa_pkg::xlen_t     redirect_pc,
  output logic                  halt,
  output core_pkg::retire_t     retire
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  xlen_t         op_a;
  xlen_t         op_b;
  logic [XLEN:0] diff;     // extra bit is the borrow
  logic          eq;
  logic          lt;
  logic          ltu;
  shamt_t        shamt;
  xlen_t         alu_res;
  xlen_t         pc_plus4;
  xlen_t         pc_imm;
  xlen_t         target;
  logic          cond;
  logic          taken;

  assign rs1_addr = dec.rs1;
  assign rs2_addr = dec.rs2;

  assign op_a = rs1_data;
  assign op_b = dec.use_imm ? dec.imm : rs2_data;

  // one subtractor serves sub, slt(u) and all six branches
  assign diff  = {1'b0, op_a} - {1'b0, op_b};
  assign eq    = (diff[XLEN-1:0] == '0);
  assign ltu   = diff[XLEN];
  assign lt    = (op_a[XLEN-1] != op_b[XLEN-1]) ? op_a[XLEN-1] : diff[XLEN-1];
  assign shamt = op_b[$bits(shamt_t)-1:0];

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = diff[XLEN-1:0];
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_OR:   alu_res = op_a | op_b;
      ALU_AND:  alu_res = op_a & op_b;
      ALU_SLL:  alu_res = op_a << shamt;
      ALU_SRL:  alu_res = op_a >> shamt;
      ALU_SRA:  alu_res = xlen_t'($signed(op_a) >>> shamt);
      ALU_SLT:  alu_res = xlen_t'(lt);
      ALU_SLTU: alu_res = xlen_t'(ltu);
      default:  alu_res = '0;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      F3_BEQ:  cond = eq;
      F3_BNE:  cond = !eq;
      F3_BLT:  cond = lt;
      F3_BGE:  cond = !lt;
      F3_BLTU: cond = ltu;
      F3_BGEU: cond = !ltu;
      default: cond = 1'b0;  // reserved encodings fall through
    endcase
  end

  assign pc_plus4 = dec.pc + 32'd4;
  assign pc_imm   = dec.pc + dec.imm;  // branch / jal target, auipc result
  assign target   = dec.is_jalr ? ((rs1_data + dec.imm) & ~xlen_t'(1)) : pc_imm;
  assign taken    = dec.is_jal || dec.is_jalr || (dec.is_branch && cond);

  always_comb begin
    case (dec.wb_sel)
      WB_LINK:   rf_wdata = pc_plus4;
      WB_IMM:    rf_wdata = dec.imm;
      WB_PC_IMM: rf_wdata = pc_imm;
      default:   rf_wdata = alu_res;
    endcase
  end

  assign rf_we    = dec_valid && dec.reg_we && !dec.is_halt;
  assign rf_waddr = dec.rd;

  assign redirect_valid = dec_valid;
  assign redirect_pc    = taken ? target : pc_plus4;
  assign halt           = dec_valid && dec.is_halt;

  always_comb begin
    retire.valid   = dec_valid;
    retire.pc      = dec.pc;
    retire.rd      = dec.rd;
    retire.we      = rf_we;
    retire.wdata   = rf_wdata;
    retire.next_pc = redirect_pc;
  end

endmodule

// ==== design/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
  parameter rv_isa_pkg::xlen_t reset_pc = 32'h8000_0000
) (
  input  logic              clk,
  input  logic              arst_n,
  output logic              psel,
  output logic              penable,
  output rv_isa_pkg::xlen_t paddr,
  input  rv_isa_pkg::inst_t prdata,
  input  logic              pready,
  output core_pkg::retire_t retire,
  output logic              halted
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  logic      fetch_valid;
  inst_t     fetch_inst;
  xlen_t     fetch_pc;
  logic      dec_valid;
  decoded_t  dec;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  logic      rf_we;
  reg_addr_t rf_waddr;
  xlen_t     rf_wdata;
  logic      redirect_valid;
  xlen_t     redirect_pc;
  logic      halt;

  fetch_unit #(
    .reset_pc (reset_pc)
  ) u_fetch_unit (
    .clk            (clk),
    .arst_n         (arst_n),
    .psel           (psel),
    .penable        (penable),
    .paddr          (paddr),
    .prdata         (prdata),
    .pready         (pready),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .halt           (halt),
    .fetch_valid    (fetch_valid),
    .fetch_inst     (fetch_inst),
    .fetch_pc       (fetch_pc),
    .halted         (halted)
  );

  decode_stage u_decode_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch_inst  (fetch_inst),
    .fetch_pc    (fetch_pc),
    .dec_valid   (dec_valid),
    .dec         (dec)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rf_we),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata)
  );

  execute_unit u_execute_unit (
    .dec_valid      (dec_valid),
    .dec            (dec),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .rf_we          (rf_we),
    .rf_waddr       (rf_waddr),
    .rf_wdata       (rf_wdata),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .halt           (halt),
    .retire         (retire)
  );

endmodule

// ==== dv/tb_rv_core_checks.svh ====
logic  seen_first;
logic  ebreak_seen;
logic  prev_psel;
xlen_t prev_paddr;

task automatic compare_field(string name, xlen_t exp, xlen_t act, int cat);
  test_checks[cat]++;
  assert (exp == act) else begin
    $display("mismatch %s at pc %h exp %h got %h", name, model_pc, exp, act);
    test_errs[cat]++;
  end
endtask

task automatic check_retire();
  logic  we;
  xlen_t wdata;
  xlen_t next;
  int    cat;
  inst_t w;
  w = fetch_word(model_pc);
  model_exec(w, we, wdata, next, cat);
  if (cat == 5) ebreak_seen = 1'b1;
  compare_field("retire.pc", model_pc, retire.pc, cat);
  compare_field("retire.we", xlen_t'(we), xlen_t'(retire.we), cat);
  compare_field("retire.next_pc", next, retire.next_pc, cat);
  if (we) begin
    compare_field("retire.rd", xlen_t'(w[11:7]), xlen_t'(retire.rd), cat);
    compare_field("retire.wdata", wdata, retire.wdata, cat);
    if (w[11:7] != 5'd0) model_regs[w[11:7]] = wdata;
  end
  model_pc = next;
endtask

task automatic check_apb_cycle();
  if (!arst_n) begin
    assert (!psel && !penable && !retire.valid && !halted) else begin
      $display("psel, penable, retire.valid or halted active while reset is asserted");
      test_errs[0]++;
    end
    seen_first  = 1'b0;
    ebreak_seen = 1'b0;
  end else begin
    if (psel && !seen_first) begin
      compare_field("paddr", BASE_ADDR, paddr, 0);  // first fetch at reset_pc
      seen_first = 1'b1;
    end
    if (penable) begin
      test_checks[0]++;
      assert (psel && prev_psel) else begin
        $display("access phase without a preceding setup phase");
        test_errs[0]++;
      end
      compare_field("paddr", prev_paddr, paddr, 0);  // held since setup
    end
    assert (!(halted && psel)) else begin
      $display("setup phase issued after halt");
      test_errs[5]++;
    end
    assert (!halted || ebreak_seen) else begin
      $display("halted rose before ebreak retired");
      test_errs[5]++;
    end
  end
  prev_psel  = psel;
  prev_paddr = paddr;
endtask

task automatic check_quiet_after_halt(int n);
  for (int i = 0; i < n; i++) begin
    @(negedge clk);
    test_checks[5]++;
    assert (halted && !psel) else begin
      $display("core left halt or fetched again, cycle %0d after halt", i);
      test_errs[5]++;
    end
  end
endtask

function automatic int report_all();
  string names[6];
  string status;
  int    failed;
  names  = '{"apb protocol", "alu ops", "lui auipc", "branches", "jumps", "ebreak halt"};
  failed = 0;
  for (int t = 0; t < 6; t++) begin
    if (test_errs[t] != 0 || test_checks[t] == 0) begin
      failed++;
      status = "failed";
    end else begin
      status = "ok";
    end
    $display("test %-12s checks %0d errors %0d %s", names[t], test_checks[t],
             test_errs[t], status);
  end
  $display("tests passed %0d failed %0d", 6 - failed, failed);
  return failed;
endfunction

// ==== dv/tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;
  import rv_isa_pkg::*;
  import core_pkg::*;

  localparam xlen_t BASE_ADDR  = 32'h8000_0000;
  localparam int    CLK_PERIOD = 40;
  localparam int    RUN_LIMIT  = 3000;  // cycles until halt

  logic    clk;
  logic    arst_n;
  logic    psel;
  logic    penable;
  xlen_t   paddr;
  inst_t   prdata;
  logic    pready;
  retire_t retire;
  logic    halted;

  inst_t       prog[$];
  logic [31:0] lcg_state;
  int          wait_left;
  xlen_t       model_regs[32];
  xlen_t       model_pc;
  int          test_checks[6];  // apb, alu, upper, branch, jump, halt
  int          test_errs[6];
  int          cycles;

  rv_core_top #(
    .reset_pc (BASE_ADDR)
  ) u_rv_core_top (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .paddr   (paddr),
    .prdata  (prdata),
    .pready  (pready),
    .retire  (retire),
    .halted  (halted)
  );

  `include "tb_rv_core_checks.svh"

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic inst_t enc_r(logic [6:0] f7, int rs2, int rs1, int f3, int rd);
    return {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP};
  endfunction

  function automatic inst_t enc_i(logic [6:0] op, int f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic inst_t enc_u(logic [6:0] op, int rd, int imm20);
    return {imm20[19:0], rd[4:0], op};
  endfunction

  function automatic inst_t enc_j(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], JAL};
  endfunction

  function automatic inst_t enc_b(int f3, int rs1, int rs2, int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], BRANCH};
  endfunction

  task automatic build_program();
    inst_t trap;
    trap = enc_i(OP_IMM, 0, 31, 0, 1);  // only reached if a jump goes wrong
    // x1 = 100 and x2 = -7 stay live for the branches
    prog.push_back(enc_i(OP_IMM, 0, 1, 0, 100));
    prog.push_back(enc_i(OP_IMM, 0, 2, 0, -7));
    prog.push_back(enc_r(7'h00, 2, 1, 0, 3));   // add
    prog.push_back(enc_r(7'h20, 1, 2, 0, 4));   // sub
    prog.push_back(enc_r(7'h00, 2, 1, 4, 5));   // xor
    prog.push_back(enc_r(7'h00, 2, 1, 6, 6));   // or
    prog.push_back(enc_r(7'h00, 2, 1, 7, 7));   // and
    prog.push_back(enc_i(OP_IMM, 4, 8, 2, 'h55));
    prog.push_back(enc_i(OP_IMM, 6, 26, 1, -256));
    prog.push_back(enc_i(OP_IMM, 7, 27, 2, 'h0f0));
    prog.push_back(enc_i(OP_IMM, 0, 9, 0, 3));
    prog.push_back(enc_r(7'h00, 9, 2, 1, 10));  // sll
    prog.push_back(enc_r(7'h00, 9, 2, 5, 11));  // srl
    prog.push_back(enc_r(7'h20, 9, 2, 5, 12));  // sra
    prog.push_back(enc_i(OP_IMM, 1, 13, 1, 4));
    prog.push_back(enc_i(OP_IMM, 5, 14, 2, 28));
    prog.push_back(enc_i(OP_IMM, 5, 15, 2, 'h402));  // srai by 2
    prog.push_back(enc_r(7'h00, 1, 2, 2, 16));  // slt negative vs positive
    prog.push_back(enc_r(7'h00, 1, 2, 3, 17));  // sltu on the same pair
    prog.push_back(enc_i(OP_IMM, 2, 18, 1, -1));
    prog.push_back(enc_i(OP_IMM, 3, 19, 1, -1));
    prog.push_back(enc_r(7'h00, 1, 1, 0, 0));   // write to x0
    prog.push_back(enc_r(7'h00, 1, 0, 0, 20));  // x0 must still read zero
    prog.push_back(enc_u(LUI, 21, 'habcde));
    prog.push_back(enc_u(AUIPC, 22, 'h12345));
    // each condition taken over a trap word, then not taken
    for (int f = 0; f < 8; f++) begin
      if (f == 2 || f == 3) continue;
      prog.push_back(enc_b(f, (f == 4 || f == 7) ? 2 : 1, (f == 4 || f == 7) ? 1 : 2, 8));
      prog.push_back(trap);
      prog.push_back(enc_b(f, (f == 4 || f == 7) ? 1 : 2, (f == 4 || f == 7) ? 2 : 1, 8));
      if (f == 0) begin
        prog[prog.size() - 3] = enc_b(0, 1, 1, 8);  // beq needs equal operands
      end
      if (f == 1) begin
        prog[prog.size() - 1] = enc_b(1, 1, 1, 8);
      end
    end
    prog.push_back(enc_j(23, 8));
    prog.push_back(trap);
    prog.push_back(enc_u(AUIPC, 24, 0));
    prog.push_back(enc_i(JALR, 0, 25, 24, 13));  // odd target with bit 0 dropped
    prog.push_back(trap);
    prog.push_back(INST_EBREAK);
  endtask

  function automatic inst_t fetch_word(xlen_t addr);
    int idx;
    idx = int'((addr - BASE_ADDR) >> 2);
    if (addr >= BASE_ADDR && idx < prog.size()) begin
      return prog[idx];
    end
    return INST_EBREAK;
  endfunction

  // apb memory with random wait states per transfer
  always @(posedge clk) begin
    #2;
    if (psel && !penable) begin
      wait_left = int'((lcg_next() >> 16) % 4);
      pready    = 1'b0;
    end else if (psel && penable && wait_left == 0) begin
      pready = 1'b1;
      prdata = fetch_word(paddr);
    end else if (psel && penable) begin
      wait_left--;
      pready = 1'b0;
    end else begin
      pready = 1'b0;
    end
  end

  // reference model by the RV32I rules
  task automatic model_exec(input inst_t w, output logic we, output xlen_t wdata,
                            output xlen_t next, output int cat);
    xlen_t a;
    xlen_t b;
    xlen_t imm_i;
    xlen_t imm_b;
    logic  cond;
    a     = model_regs[w[19:15]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    b     = (w[6:0] == OP) ? model_regs[w[24:20]] : imm_i;
    we    = 1'b1;
    wdata = '0;
    next  = model_pc + 4;
    cat   = 1;
    case (w[6:0])
      OP, OP_IMM: begin
        case (w[14:12])
          3'd0: wdata = (w[6:0] == OP && w[30]) ? a - b : a + b;
          3'd1: wdata = a << b[4:0];
          3'd2: wdata = {31'b0, $signed(a) < $signed(b)};
          3'd3: wdata = {31'b0, a < b};
          3'd4: wdata = a ^ b;
          3'd5: wdata = w[30] ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'd6: wdata = a | b;
          default: wdata = a & b;
        endcase
      end
      LUI, AUIPC: begin
        cat   = 2;
        wdata = {w[31:12], 12'h000} + ((w[6:0] == AUIPC) ? model_pc : '0);
      end
      JAL, JALR: begin
        cat   = 4;
        wdata = model_pc + 4;
        next  = (w[6:0] == JAL) ?
                model_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0} :
                (a + imm_i) & ~32'h1;
      end
      BRANCH: begin
        cat = 3;
        we  = 1'b0;
        b   = model_regs[w[24:20]];
        case (w[14:12])
          3'd0: cond = (a == b);
          3'd1: cond = (a != b);
          3'd4: cond = $signed(a) < $signed(b);
          3'd5: cond = $signed(a) >= $signed(b);
          3'd6: cond = a < b;
          default: cond = a >= b;
        endcase
        if (cond) next = model_pc + imm_b;
      end
      default: begin
        cat = 5;  // ebreak
        we  = 1'b0;
      end
    endcase
  endtask

  always @(negedge clk) begin
    check_apb_cycle();
    if (arst_n && retire.valid) begin
      check_retire();
    end
  end

  initial begin
    arst_n    = 1'b0;
    pready    = 1'b0;
    prdata    = '0;
    lcg_state = 32'h6680_5542;
    wait_left = 0;
    model_pc  = BASE_ADDR;
    foreach (model_regs[i]) model_regs[i] = '0;
    build_program();
    repeat (5) @(posedge clk);
    #2 arst_n = 1'b1;
    cycles = 0;
    while (!halted && cycles < RUN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("timeout, halted did not rise within %0d cycles", RUN_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end else begin
      check_quiet_after_halt(20);
      if (report_all() == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

// ==== files.f ====
+incdir+dv
design/rv_isa_pkg.sv
design/core_pkg.sv
design/fetch_unit.sv
design/decode_stage.sv
design/reg_file.sv
design/execute_unit.sv
design/rv_core_top.sv
dv/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_rv_core -f files.f \
  --Mdir obj_dir -o sim_rv_core > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_rv_core > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -q "RESULT: PASS" sim.log; then
  exit 0
fi
exit 1
